// ==== Bender.yml ====
package:
  name: topmodule_wb

sources:
  - rtl/soc_pkg.sv
  - rtl/wb_if.sv
  - rtl/wb_interconnect.sv
  - rtl/wb_ram.sv
  - rtl/wb_gpio.sv
  - rtl/wb_timer.sv
  - rtl/topmodule.sv
  - target: test
    files:
      - tb/topmodule_asserts.sv
      - tb/tb_topmodule.sv

// ==== rtl/soc_pkg.sv ====
package soc_pkg;

	// Bus widths
	localparam int adr_w = 32;
	localparam int dat_w = 32;
	localparam int sel_w = 4;

	// Region select sits in the top address nibble
	localparam int region_w = 4;
	localparam logic [region_w-1:0] region_ram   = 4'h0;
	localparam logic [region_w-1:0] region_gpio  = 4'h1;
	localparam logic [region_w-1:0] region_timer = 4'h2;

	localparam int ram_words = 256; // 1 KiB
	localparam int ram_aw    = $clog2(ram_words);

	// Register offsets inside a region
	localparam logic [3:0] gpio_led  = 4'h0;
	localparam logic [3:0] gpio_btn  = 4'h4;
	localparam logic [3:0] gpio_edge = 4'h8;

	localparam logic [3:0] tmr_count   = 4'h0;
	localparam logic [3:0] tmr_compare = 4'h4;
	localparam logic [3:0] tmr_status  = 4'h8;

	localparam logic [dat_w-1:0] unmapped_data = '0;

	// Bit positions in the interrupt vector
	localparam int irq_timer = 0;
	localparam int irq_gpio  = 1;

	// Replace only the bytes whose select bit is set
	function automatic logic [dat_w-1:0] byte_merge(input logic [dat_w-1:0] old_w,
			input logic [dat_w-1:0] new_w, input logic [sel_w-1:0] sel);
		logic [dat_w-1:0] res;
		res = old_w;
		for (int i = 0; i < sel_w; i++) begin
			if (sel[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
		end
		return res;
	endfunction

endpackage

// ==== rtl/topmodule.sv ====
`timescale 1ns/1ps

module topmodule import soc_pkg::*; (
	input  logic        clk_25mhz,
	input  logic        rst_n_i,

	// Master port the CPU would drive
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	input  logic [3:0]  wb_sel_i,
	input  logic        wb_we_i,
	input  logic        wb_stb_i,
	input  logic        wb_cyc_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,

	input  logic [7:0]  btn_i,
	output logic [7:0]  led_o,
	output logic [1:0]  irq_o
);

	logic gpio_irq;
	logic tmr_irq;

	wb_if cpu_bus ();
	wb_if ram_bus ();
	wb_if gpio_bus ();
	wb_if tmr_bus ();

	assign cpu_bus.adr   = wb_adr_i;
	assign cpu_bus.dat_m = wb_dat_i;
	assign cpu_bus.sel   = wb_sel_i;
	assign cpu_bus.we    = wb_we_i;
	assign cpu_bus.stb   = wb_stb_i;
	assign cpu_bus.cyc   = wb_cyc_i;
	assign wb_dat_o      = cpu_bus.dat_s;
	assign wb_ack_o      = cpu_bus.ack;

	wb_interconnect xbar_i (
		.clk_25mhz(clk_25mhz),
		.rst_n_i  (rst_n_i),
		.m        (cpu_bus.slave),
		.s_ram    (ram_bus.master),
		.s_gpio   (gpio_bus.master),
		.s_tmr    (tmr_bus.master)
	);

	wb_ram ram_i (
		.clk_25mhz(clk_25mhz),
		.rst_n_i  (rst_n_i),
		.bus      (ram_bus.slave)
	);

	wb_gpio gpio_i (
		.clk_25mhz(clk_25mhz),
		.rst_n_i  (rst_n_i),
		.bus      (gpio_bus.slave),
		.btn_i    (btn_i),
		.led_o    (led_o),
		.irq_o    (gpio_irq)
	);

	wb_timer timer_i (
		.clk_25mhz(clk_25mhz),
		.rst_n_i  (rst_n_i),
		.bus      (tmr_bus.slave),
		.irq_o    (tmr_irq)
	);

	// Interrupt lines as the core would see them
	assign irq_o[irq_timer] = tmr_irq;
	assign irq_o[irq_gpio]  = gpio_irq;

endmodule

// ==== rtl/wb_gpio.sv ====
`timescale 1ns/1ps

module wb_gpio import soc_pkg::*; (
	input  logic       clk_25mhz,
	input  logic       rst_n_i,
	wb_if.slave        bus,
	input  logic [7:0] btn_i,
	output logic [7:0] led_o,
	output logic       irq_o
);

	logic [7:0]       btn_s1;
	logic [7:0]       btn_s2;
	logic [7:0]       rise;
	logic [7:0]       led_q;
	logic [7:0]       edge_q;
	logic [7:0]       edge_d;
	logic [7:0]       edge_clr;
	logic [dat_w-1:0] wr_word;
	logic [dat_w-1:0] rdata_q;
	logic             ack_q;
	logic             irq_q;
	logic             access;
	logic             wr;

	assign access = bus.stb & bus.cyc & ~ack_q;
	assign wr     = access & bus.we;

	// Edge shows up in the same cycle as the synchronized level
	assign rise = btn_s1 & ~btn_s2;

	assign wr_word  = byte_merge({24'b0, led_q}, bus.dat_m, bus.sel);
	assign edge_clr = (wr && bus.adr[3:0] == gpio_edge && bus.sel[0]) ? bus.dat_m[7:0] : 8'h00;
	assign edge_d   = (edge_q & ~edge_clr) | rise; // New edge beats clear

	always_ff @(posedge clk_25mhz or negedge rst_n_i) begin
		if (!rst_n_i) begin
			btn_s1 <= '0;
			btn_s2 <= '0;
			led_q  <= '0;
			edge_q <= '0;
			irq_q  <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			btn_s1 <= btn_i;
			btn_s2 <= btn_s1;
			edge_q <= edge_d;
			irq_q  <= |edge_d;
			ack_q  <= access;
			if (wr && bus.adr[3:0] == gpio_led) led_q <= wr_word[7:0];
		end
	end

	always_ff @(posedge clk_25mhz) begin
		if (access) begin
			case (bus.adr[3:0])
				gpio_led:  rdata_q <= {24'b0, led_q};
				gpio_btn:  rdata_q <= {24'b0, btn_s2};
				gpio_edge: rdata_q <= {24'b0, edge_q};
				default:   rdata_q <= '0;
			endcase
		end
	end

	assign bus.dat_s = rdata_q;
	assign bus.ack   = ack_q;
	assign led_o     = led_q;
	assign irq_o     = irq_q;

endmodule

// ==== rtl/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if import soc_pkg::*; ();

	logic [adr_w-1:0] adr;
	logic [dat_w-1:0] dat_m;   // Write data
	logic [dat_w-1:0] dat_s;   // Read data
	logic [sel_w-1:0] sel;
	logic             we;
	logic             stb;
	logic             cyc;
	logic             ack;

	modport master (
		output adr, dat_m, sel, we, stb, cyc,
		input  dat_s, ack
	);

	modport slave (
		input  adr, dat_m, sel, we, stb, cyc,
		output dat_s, ack
	);

endinterface

// ==== rtl/wb_interconnect.sv ====
`timescale 1ns/1ps

module wb_interconnect import soc_pkg::*; (
	input logic clk_25mhz,
	input logic rst_n_i,
	wb_if.slave m,
	wb_if.master s_ram,
	wb_if.master s_gpio,
	wb_if.master s_tmr
);

	logic [region_w-1:0] region;
	logic sel_ram;
	logic sel_gpio;
	logic sel_tmr;
	logic sel_none;
	logic none_ack_q; // Ack for cycles that hit no slave

	assign region   = m.adr[adr_w-1 -: region_w];
	assign sel_ram  = (region == region_ram);
	assign sel_gpio = (region == region_gpio);
	assign sel_tmr  = (region == region_timer);
	assign sel_none = ~(sel_ram | sel_gpio | sel_tmr);

	// Request fans out to all slaves, strobes only to the selected one
	assign s_ram.adr    = m.adr;
	assign s_ram.dat_m  = m.dat_m;
	assign s_ram.sel    = m.sel;
	assign s_ram.we     = m.we;
	assign s_ram.stb    = m.stb & sel_ram;
	assign s_ram.cyc    = m.cyc & sel_ram;

	assign s_gpio.adr   = m.adr;
	assign s_gpio.dat_m = m.dat_m;
	assign s_gpio.sel   = m.sel;
	assign s_gpio.we    = m.we;
	assign s_gpio.stb   = m.stb & sel_gpio;
	assign s_gpio.cyc   = m.cyc & sel_gpio;

	assign s_tmr.adr    = m.adr;
	assign s_tmr.dat_m  = m.dat_m;
	assign s_tmr.sel    = m.sel;
	assign s_tmr.we     = m.we;
	assign s_tmr.stb    = m.stb & sel_tmr;
	assign s_tmr.cyc    = m.cyc & sel_tmr;

	// Unmapped region answers on its own, writes go nowhere
	always_ff @(posedge clk_25mhz or negedge rst_n_i) begin
		if (!rst_n_i) none_ack_q <= 1'b0;
		else none_ack_q <= m.stb & m.cyc & sel_none & ~none_ack_q;
	end

	always_comb begin
		if (sel_ram) begin
			m.dat_s = s_ram.dat_s;
			m.ack   = s_ram.ack;
		end else if (sel_gpio) begin
			m.dat_s = s_gpio.dat_s;
			m.ack   = s_gpio.ack;
		end else if (sel_tmr) begin
			m.dat_s = s_tmr.dat_s;
			m.ack   = s_tmr.ack;
		end else begin
			m.dat_s = unmapped_data;
			m.ack   = none_ack_q;
		end
	end

endmodule

// ==== rtl/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram import soc_pkg::*; (
	input logic clk_25mhz,
	input logic rst_n_i,
	wb_if.slave bus
);

	logic [dat_w-1:0]  mem [ram_words];
	logic [dat_w-1:0]  rdata_q;
	logic [ram_aw-1:0] idx;
	logic              ack_q;
	logic              access;

	assign idx    = bus.adr[ram_aw+1:2]; // Word index
	assign access = bus.stb & bus.cyc & ~ack_q;

	always_ff @(posedge clk_25mhz or negedge rst_n_i) begin
		if (!rst_n_i) ack_q <= 1'b0;
		else ack_q <= access;
	end

	// Byte-merged write, read returns the old word
	always_ff @(posedge clk_25mhz) begin
		if (access) begin
			if (bus.we) mem[idx] <= byte_merge(mem[idx], bus.dat_m, bus.sel);
			rdata_q <= mem[idx];
		end
	end

	assign bus.dat_s = rdata_q;
	assign bus.ack   = ack_q;

endmodule

// ==== rtl/wb_timer.sv ====
`timescale 1ns/1ps

module wb_timer import soc_pkg::*; (
	input  logic clk_25mhz,
	input  logic rst_n_i,
	wb_if.slave  bus,
	output logic irq_o
);

	logic [dat_w-1:0] count_q;
	logic [dat_w-1:0] cmp_q;
	logic [dat_w-1:0] rdata_q;
	logic             match_q;
	logic             ack_q;
	logic             access;
	logic             wr;
	logic             clr;

	assign access = bus.stb & bus.cyc & ~ack_q;
	assign wr     = access & bus.we;
	assign clr    = wr && bus.adr[3:0] == tmr_status && bus.sel[0] && bus.dat_m[0];

	always_ff @(posedge clk_25mhz or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
			cmp_q   <= '1; // Far away after reset
			match_q <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			ack_q <= access;
			if (wr && bus.adr[3:0] == tmr_count)
				count_q <= byte_merge(count_q, bus.dat_m, bus.sel);
			else
				count_q <= count_q + 1'b1;
			if (wr && bus.adr[3:0] == tmr_compare)
				cmp_q <= byte_merge(cmp_q, bus.dat_m, bus.sel);
			if (count_q == cmp_q) match_q <= 1'b1; // Set wins over clear
			else if (clr) match_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_25mhz) begin
		if (access) begin
			case (bus.adr[3:0])
				tmr_count:   rdata_q <= count_q;
				tmr_compare: rdata_q <= cmp_q;
				tmr_status:  rdata_q <= {{(dat_w-1){1'b0}}, match_q};
				default:     rdata_q <= '0;
			endcase
		end
	end

	assign bus.dat_s = rdata_q;
	assign bus.ack   = ack_q;
	assign irq_o     = match_q;

endmodule

// ==== tb/tb_topmodule.sv ====
`timescale 1ns/1ps

module tb_topmodule import soc_pkg::*; ();

	localparam int clk_period  = 40;
	localparam int n_trans     = 900; // Bus cycles over all tests
	localparam int timeout_cyc = n_trans * 10 + 2000;

	logic        clk_25mhz;
	logic        rst_n_i;
	logic [31:0] bus_adr;
	logic [31:0] bus_wdat;
	logic [3:0]  bus_sel;
	logic        bus_we;
	logic        bus_stb;
	logic        bus_cyc;
	logic [31:0] bus_rdat;
	logic        bus_ack;
	logic [7:0]  btn;
	logic [7:0]  led;
	logic [1:0]  irq;

	// Reference model
	logic [31:0] ram_m [ram_words];
	logic [7:0]  led_m;
	logic [7:0]  edge_m;
	logic [31:0] cmp_m;
	int          errors;
	int          checks;

	topmodule dut_i (
		.clk_25mhz(clk_25mhz),
		.rst_n_i  (rst_n_i),
		.wb_adr_i (bus_adr),
		.wb_dat_i (bus_wdat),
		.wb_sel_i (bus_sel),
		.wb_we_i  (bus_we),
		.wb_stb_i (bus_stb),
		.wb_cyc_i (bus_cyc),
		.wb_dat_o (bus_rdat),
		.wb_ack_o (bus_ack),
		.btn_i    (btn),
		.led_o    (led),
		.irq_o    (irq)
	);

	always #(clk_period / 2) clk_25mhz = ~clk_25mhz;

	function automatic logic [31:0] reg_adr(input logic [3:0] region, input int offs);
		return {region, offs[27:0]};
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
		end
	endtask

	// Entered 1 ns after a rising edge, leaves the same way
	task automatic bus_cycle(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, input logic we, output logic [31:0] rdata);
		bit got_ack;
		got_ack  = 1'b0;
		rdata    = 'x;
		bus_adr  = adr;
		bus_wdat = dat;
		bus_sel  = sel;
		bus_we   = we;
		bus_stb  = 1'b1;
		bus_cyc  = 1'b1;
		for (int i = 0; i < 4 && !got_ack; i++) begin
			@(negedge clk_25mhz); // Ack and data are stable here
			if (bus_ack) begin
				got_ack = 1'b1;
				rdata   = bus_rdat;
			end
		end
		if (!got_ack) begin
			errors++;
			$display("Bus cycle to address 0x%08h was never acknowledged", adr);
		end
		@(posedge clk_25mhz);
		#1;
		bus_stb = 1'b0;
		bus_cyc = 1'b0;
		bus_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		bus_cycle(adr, dat, sel, 1'b1, unused);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
		bus_cycle(adr, 32'h0, 4'hf, 1'b0, dat);
	endtask

	initial begin
		#(longint'(timeout_cyc) * clk_period);
		$display("Timeout: the run did not finish within %0d cycles", timeout_cyc);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] wd;
		logic [31:0] adr;
		logic [7:0]  btn_new;
		logic [3:0]  sel;
		int          idx;
		bit          fired;
		void'($urandom(88711));
		clk_25mhz = 1'b0;
		rst_n_i   = 1'b0;
		bus_adr   = '0;
		bus_wdat  = '0;
		bus_sel   = '0;
		bus_we    = 1'b0;
		bus_stb   = 1'b0;
		bus_cyc   = 1'b0;
		btn       = '0;
		errors    = 0;
		checks    = 0;
		led_m     = '0;
		edge_m    = '0;
		cmp_m     = '1;
		repeat (2) @(posedge clk_25mhz);
		#1;
		rst_n_i = 1'b1;
		compare("led_o", 32'h0, led);
		compare("irq_o", 32'h0, irq);

		// Fill the RAM so every word is known, then partial writes mixed with reads
		for (int i = 0; i < ram_words; i++) begin
			wd = $urandom;
			wb_write(reg_adr(region_ram, i * 4), wd, 4'hf);
			ram_m[i] = wd;
		end
		for (int i = 0; i < 200; i++) begin
			idx = $urandom % ram_words;
			wd  = $urandom;
			sel = $urandom;
			wb_write(reg_adr(region_ram, idx * 4), wd, sel);
			for (int b = 0; b < 4; b++) begin
				if (sel[b]) ram_m[idx][b*8 +: 8] = wd[b*8 +: 8];
			end
			idx = $urandom % ram_words;
			wb_read(reg_adr(region_ram, idx * 4), rd);
			compare("wb_dat_o (ram)", ram_m[idx], rd);
		end

		for (int i = 0; i < 20; i++) begin
			wd = $urandom;
			wb_write(reg_adr(region_gpio, gpio_led), wd, 4'hf);
			led_m = wd[7:0];
			compare("led_o", led_m, led);
			wb_read(reg_adr(region_gpio, gpio_led), rd);
			compare("wb_dat_o (gpio_led)", {24'h0, led_m}, rd);
		end

		for (int i = 0; i < 20; i++) begin
			btn_new = $urandom;
			edge_m  = edge_m | (btn_new & ~btn); // Rising bits only
			btn     = btn_new;
			repeat (3) @(posedge clk_25mhz);
			#1;
			wb_read(reg_adr(region_gpio, gpio_btn), rd);
			compare("wb_dat_o (gpio_btn)", {24'h0, btn}, rd);
			wb_read(reg_adr(region_gpio, gpio_edge), rd);
			compare("wb_dat_o (gpio_edge)", {24'h0, edge_m}, rd);
			compare("irq_o[irq_gpio]", |edge_m, irq[irq_gpio]);
			wb_write(reg_adr(region_gpio, gpio_edge), rd, 4'hf);
			edge_m = edge_m & ~rd[7:0];
			compare("irq_o[irq_gpio]", |edge_m, irq[irq_gpio]);
		end

		for (int i = 0; i < 3; i++) begin
			wb_read(reg_adr(region_timer, tmr_count), rd);
			cmp_m = rd + 20 + $urandom % 81;
			wb_write(reg_adr(region_timer, tmr_compare), cmp_m, 4'hf);
			fired = 1'b0;
			for (int c = 0; c < 200 && !fired; c++) begin
				@(negedge clk_25mhz);
				fired = irq[irq_timer];
			end
			if (!fired) begin
				errors++;
				$display("Timer interrupt never rose after the compare write");
			end
			@(posedge clk_25mhz);
			#1;
			wb_read(reg_adr(region_timer, tmr_status), rd);
			compare("wb_dat_o (tmr_status)", 32'h1, rd);
			wb_write(reg_adr(region_timer, tmr_status), 32'h1, 4'hf);
			compare("irq_o[irq_timer]", 32'h0, irq[irq_timer]);
		end

		// Pending edges expose a stray clear from the unmapped writes
		btn = 8'h00;
		repeat (3) @(posedge clk_25mhz);
		#1;
		btn    = 8'hff;
		edge_m = 8'hff;
		repeat (3) @(posedge clk_25mhz);
		#1;

		// Regions 0x3 to 0xF hit no slave
		for (int i = 0; i < 30; i++) begin
			adr        = $urandom;
			adr[31:28] = 3 + $urandom % 13;
			wb_write(adr, $urandom, 4'hf);
			wb_read(adr, rd);
			compare("wb_dat_o (unmapped)", 32'h0, rd);
		end
		for (int i = 0; i < 16; i++) begin
			idx = $urandom % ram_words;
			wb_read(reg_adr(region_ram, idx * 4), rd);
			compare("wb_dat_o (ram)", ram_m[idx], rd);
		end
		wb_read(reg_adr(region_gpio, gpio_led), rd);
		compare("wb_dat_o (gpio_led)", {24'h0, led_m}, rd);
		compare("led_o", led_m, led);
		wb_read(reg_adr(region_gpio, gpio_edge), rd);
		compare("wb_dat_o (gpio_edge)", {24'h0, edge_m}, rd);
		wb_read(reg_adr(region_timer, tmr_compare), rd);
		compare("wb_dat_o (tmr_compare)", cmp_m, rd);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/topmodule_asserts.sv ====
`timescale 1ns/1ps

module topmodule_asserts (
	input logic       clk_25mhz,
	input logic       rst_n_i,
	input logic       stb_i,
	input logic       ack_i,
	input logic [1:0] irq_i
);

	ack_single: assert property (@(posedge clk_25mhz) disable iff (!rst_n_i)
		ack_i |=> !ack_i)
		else $error("wb_ack_o high for two cycles in a row");

	ack_needs_stb: assert property (@(posedge clk_25mhz) disable iff (!rst_n_i)
		ack_i |-> stb_i)
		else $error("wb_ack_o high without wb_stb_i");

	// Quiet outputs in the first cycle out of reset
	reset_quiet: assert property (@(posedge clk_25mhz)
		$rose(rst_n_i) |-> (irq_i == 2'b00 && !ack_i))
		else $error("irq_o or wb_ack_o high right after reset");

endmodule

bind topmodule topmodule_asserts asserts_i (
	.clk_25mhz(clk_25mhz),
	.rst_n_i  (rst_n_i),
	.stb_i    (wb_stb_i),
	.ack_i    (wb_ack_o),
	.irq_i    (irq_o)
);

// ==== vlog.f ====
rtl/soc_pkg.sv
rtl/wb_if.sv
rtl/wb_interconnect.sv
rtl/wb_ram.sv
rtl/wb_gpio.sv
rtl/wb_timer.sv
rtl/topmodule.sv
tb/topmodule_asserts.sv
tb/tb_topmodule.sv
